/* hw/mem_map_pkg.sv */
// sram memory map: bus widths, client address widths and partition prefixes
`default_nettype none

package mem_map_pkg;

   // ----------------------------------------
   // sram bus
   // ----------------------------------------
   localparam int sram_addr_w = 18;
   localparam int sram_data_w = 32;

   // ----------------------------------------
   // client ports
   // ----------------------------------------
   // microcode word is split over two sram words
   localparam int mcr_addr_w  = 14;
   localparam int mcr_data_w  = 49;
   localparam int vram_addr_w = 15;
   localparam int main_addr_w = 22;
   // low main address bits that land in the sram
   localparam int main_sram_w = 17;

   // ----------------------------------------
   // partitions, top address bits
   // ----------------------------------------
   // 0xx main memory, 10x microcode, 11x video
   localparam logic [2:0] mcr_prefix  = 3'b100;
   localparam logic [2:0] vram_prefix = 3'b110;

endpackage

`default_nettype wire

/* hw/slot_pkg.sv */
// slot and access-kind types shared by the controller blocks
`default_nettype none

package slot_pkg;

   // eight-slot access cycle
   // s1/s2 microcode, s3 display, s6 cpu video or main memory
   typedef enum logic [3:0] {
      slot_s1,
      slot_s2,
      slot_s3,
      slot_s4,
      slot_s5,
      slot_s6,
      slot_s7,
      slot_s8
   } slot_t;

   // owner of slot s6 for the current cycle
   typedef enum logic [2:0] {
      acc_none,
      acc_vram_rd,
      acc_vram_wr,
      acc_main_rd,
      acc_main_wr
   } access_t;

endpackage

`default_nettype wire

/* hw/slot_sequencer.sv */
// slot sequencer: eight-slot sram access cycle, held in s1 until prefetch
`default_nettype none
`timescale 1ns/1ps

module slot_sequencer
   import slot_pkg::*;
(
   input  wire   clk,
   input  wire   reset,
   input  wire   prefetch,
   output slot_t slot
);

   slot_t slot_next;

   // ----------------------------------------
   // next slot
   // ----------------------------------------
   always_comb
   begin
      case (slot)
         // wait here for the cpu to ask for the next microcode word
         slot_s1: slot_next = prefetch ? slot_s2 : slot_s1;
         slot_s2: slot_next = slot_s3;
         slot_s3: slot_next = slot_s4;
         slot_s4: slot_next = slot_s5;
         slot_s5: slot_next = slot_s6;
         slot_s6: slot_next = slot_s7;
         slot_s7: slot_next = slot_s8;
         slot_s8: slot_next = slot_s1;
         default: slot_next = slot_s1;
      endcase
   end

   // ----------------------------------------
   // state register
   // ----------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         slot <= slot_s1;
      end
      else
      begin
         slot <= slot_next;
      end
   end

endmodule

`default_nettype wire

/* hw/sram_bus_driver.sv */
// sram bus driver: per-slot address, strobes and write data, and s6 arbitration
`default_nettype none
`timescale 1ns/1ps

module sram_bus_driver
   import mem_map_pkg::*, slot_pkg::*;
#(
   parameter int main_limit_bits = 5
)
(
   input  slot_t                   slot,
   input  wire [mcr_addr_w-1:0]    mcr_addr,
   input  wire [mcr_data_w-1:0]    mcr_data_in,
   input  wire                     mcr_write,
   input  wire [vram_addr_w-1:0]   vram_vga_addr,
   input  wire                     vram_vga_req,
   input  wire [vram_addr_w-1:0]   vram_cpu_addr,
   input  wire [sram_data_w-1:0]   vram_cpu_data_in,
   input  wire                     vram_cpu_req,
   input  wire                     vram_cpu_write,
   input  wire                     vram_cpu_busy,
   input  wire [main_addr_w-1:0]   main_addr,
   input  wire [sram_data_w-1:0]   main_data_in,
   input  wire                     main_req,
   input  wire                     main_write,
   input  wire                     main_busy,
   output access_t                 s6_access,
   output logic [sram_addr_w-1:0]  sram_a,
   output logic                    sram_oe_n,
   output logic                    sram_we_n,
   output logic [sram_data_w-1:0]  sram_dq_out,
   output logic                    sram_dq_oe
);

   logic main_in_range;
   logic rd;
   logic wr;

   // upper main address bits must be clear to reach the sram
   assign main_in_range = (main_addr[main_sram_w +: main_limit_bits] == '0);

   // ----------------------------------------
   // slot s6 owner
   // ----------------------------------------
   always_comb
   begin
      // video first, main memory waits a cycle
      // a client still showing its flag is skipped
      if (vram_cpu_req && !vram_cpu_busy)
         s6_access = acc_vram_rd;
      else if (vram_cpu_write && !vram_cpu_busy)
         s6_access = acc_vram_wr;
      else if (main_req && !main_busy)
         s6_access = acc_main_rd;
      else if (main_write && !main_busy)
         s6_access = acc_main_wr;
      else
         s6_access = acc_none;
   end

   // ----------------------------------------
   // address, direction, write data
   // ----------------------------------------
   always_comb
   begin
      sram_a      = '0;
      sram_dq_out = '0;
      rd          = 1'b0;
      wr          = 1'b0;
      case (slot)
         slot_s1:
         begin
            // microcode upper half, bit 48 on dq 16
            sram_a = {mcr_prefix, mcr_addr, 1'b0};
            sram_dq_out[mcr_data_w-sram_data_w-1:0] = mcr_data_in[mcr_data_w-1:sram_data_w];
            rd = !mcr_write;
            wr = mcr_write;
         end
         slot_s2:
         begin
            // microcode low word
            sram_a      = {mcr_prefix, mcr_addr, 1'b1};
            sram_dq_out = mcr_data_in[sram_data_w-1:0];
            rd = !mcr_write;
            wr = mcr_write;
         end
         slot_s3:
         begin
            // display fetch
            sram_a = {vram_prefix, vram_vga_addr};
            rd     = vram_vga_req;
         end
         slot_s6:
         begin
            case (s6_access)
               acc_vram_rd:
               begin
                  sram_a = {vram_prefix, vram_cpu_addr};
                  rd     = 1'b1;
               end
               acc_vram_wr:
               begin
                  sram_a      = {vram_prefix, vram_cpu_addr};
                  sram_dq_out = vram_cpu_data_in;
                  wr          = 1'b1;
               end
               acc_main_rd:
               begin
                  sram_a = {1'b0, main_addr[main_sram_w-1:0]};
                  rd     = 1'b1;
               end
               acc_main_wr:
               begin
                  sram_a      = {1'b0, main_addr[main_sram_w-1:0]};
                  sram_dq_out = main_data_in;
                  // out of range writes vanish
                  wr          = main_in_range;
               end
               default:
               begin
                  sram_a = '0;
               end
            endcase
         end
         default:
         begin
            // idle slots, bus released
            sram_a = '0;
         end
      endcase
   end

   // strobes are active low at the pins
   assign sram_oe_n  = !rd;
   assign sram_we_n  = !wr;
   assign sram_dq_oe = wr;

endmodule

`default_nettype wire

/* hw/port_capture.sv */
// port capture: read data registers and ready/done handshake of the four clients
`default_nettype none
`timescale 1ns/1ps

module port_capture
   import mem_map_pkg::*, slot_pkg::*;
#(
   parameter int main_limit_bits = 5
)
(
   input  wire                     clk,
   input  wire                     reset,
   input  slot_t                   slot,
   input  access_t                 s6_access,
   input  wire [sram_data_w-1:0]   sram_dq_in,
   input  wire                     mcr_write,
   input  wire                     vram_vga_req,
   input  wire                     vram_cpu_req,
   input  wire                     vram_cpu_write,
   input  wire [main_addr_w-1:0]   main_addr,
   input  wire                     main_req,
   input  wire                     main_write,
   output logic [mcr_data_w-1:0]   mcr_data_out,
   output logic                    mcr_ready,
   output logic                    mcr_done,
   output logic [sram_data_w-1:0]  vram_vga_data_out,
   output logic                    vram_vga_ready,
   output logic [sram_data_w-1:0]  vram_cpu_data_out,
   output logic                    vram_cpu_ready,
   output logic                    vram_cpu_done,
   output logic                    vram_cpu_busy,
   output logic [sram_data_w-1:0]  main_data_out,
   output logic                    main_ready,
   output logic                    main_done,
   output logic                    main_busy
);

   logic main_in_range;

   assign main_in_range = (main_addr[main_sram_w +: main_limit_bits] == '0);

   // ----------------------------------------
   // microcode in fixed slots s1 and s2
   // ----------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mcr_data_out <= '0;
         mcr_ready    <= 1'b0;
         mcr_done     <= 1'b0;
      end
      else
      begin
         // upper 17 bits from s1 and low word from s2
         if (slot == slot_s1 && !mcr_write)
            mcr_data_out[mcr_data_w-1:sram_data_w] <= sram_dq_in[mcr_data_w-sram_data_w-1:0];
         if (slot == slot_s2 && !mcr_write)
            mcr_data_out[sram_data_w-1:0] <= sram_dq_in;
         // one clock pulse high during s3
         mcr_ready <= (slot == slot_s2);
         mcr_done  <= (slot == slot_s2) && mcr_write;
      end
   end

   // ----------------------------------------
   // display read in slot s3
   // ----------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vram_vga_data_out <= '0;
         vram_vga_ready    <= 1'b0;
      end
      else
      begin
         if (slot == slot_s3 && vram_vga_req && !vram_vga_ready)
         begin
            vram_vga_data_out <= sram_dq_in;
            vram_vga_ready    <= 1'b1;
         end
         // flag follows the request down
         if (!vram_vga_req)
            vram_vga_ready <= 1'b0;
      end
   end

   // ----------------------------------------
   // cpu video and main memory in slot s6
   // ----------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vram_cpu_data_out <= '0;
         vram_cpu_ready    <= 1'b0;
         vram_cpu_done     <= 1'b0;
         main_data_out     <= '0;
         main_ready        <= 1'b0;
         main_done         <= 1'b0;
      end
      else
      begin
         if (slot == slot_s6)
         begin
            case (s6_access)
               acc_vram_rd:
               begin
                  vram_cpu_data_out <= sram_dq_in;
                  vram_cpu_ready    <= 1'b1;
               end
               acc_vram_wr:
                  vram_cpu_done <= 1'b1;
               acc_main_rd:
               begin
                  // beyond the partition reads as all ones
                  main_data_out <= main_in_range ? sram_dq_in : '1;
                  main_ready    <= 1'b1;
               end
               // dropped writes still complete
               acc_main_wr:
                  main_done <= 1'b1;
               default:
                  ;
            endcase
         end
         if (!vram_cpu_req)
            vram_cpu_ready <= 1'b0;
         if (!vram_cpu_write)
            vram_cpu_done <= 1'b0;
         if (!main_req)
            main_ready <= 1'b0;
         if (!main_write)
            main_done <= 1'b0;
      end
   end

   // pending flag keeps the arbiter off a served client
   assign vram_cpu_busy = vram_cpu_ready | vram_cpu_done;
   assign main_busy     = main_ready | main_done;

endmodule

`default_nettype wire

/* hw/ram_controller.sv */
// ram controller: four clients time-sliced onto one asynchronous sram bus
`default_nettype none
`timescale 1ns/1ps

module ram_controller
   import mem_map_pkg::*, slot_pkg::*;
#(
   parameter int main_limit_bits = 5
)
(
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     prefetch,
   // microcode
   input  wire [mcr_addr_w-1:0]    mcr_addr,
   input  wire [mcr_data_w-1:0]    mcr_data_in,
   input  wire                     mcr_write,
   output wire [mcr_data_w-1:0]    mcr_data_out,
   output wire                     mcr_ready,
   output wire                     mcr_done,
   // display video
   input  wire [vram_addr_w-1:0]   vram_vga_addr,
   input  wire                     vram_vga_req,
   output wire [sram_data_w-1:0]   vram_vga_data_out,
   output wire                     vram_vga_ready,
   // cpu video
   input  wire [vram_addr_w-1:0]   vram_cpu_addr,
   input  wire [sram_data_w-1:0]   vram_cpu_data_in,
   input  wire                     vram_cpu_req,
   input  wire                     vram_cpu_write,
   output wire [sram_data_w-1:0]   vram_cpu_data_out,
   output wire                     vram_cpu_ready,
   output wire                     vram_cpu_done,
   // main memory
   input  wire [main_addr_w-1:0]   main_addr,
   input  wire [sram_data_w-1:0]   main_data_in,
   input  wire                     main_req,
   input  wire                     main_write,
   output wire [sram_data_w-1:0]   main_data_out,
   output wire                     main_ready,
   output wire                     main_done,
   // sram pins, data bus split in and out
   output wire [sram_addr_w-1:0]   sram_a,
   output wire                     sram_oe_n,
   output wire                     sram_we_n,
   output wire [sram_data_w-1:0]   sram_dq_out,
   output wire                     sram_dq_oe,
   input  wire [sram_data_w-1:0]   sram_dq_in
);

   slot_t   slot;
   access_t s6_access;
   wire     vram_cpu_busy;
   wire     main_busy;

   // ----------------------------------------
   // slot timing
   // ----------------------------------------
   slot_sequencer u_slot_sequencer (
      .clk      (clk),
      .reset    (reset),
      .prefetch (prefetch),
      .slot     (slot)
   );

   // ----------------------------------------
   // bus side
   // ----------------------------------------
   sram_bus_driver #(
      .main_limit_bits (main_limit_bits)
   ) u_sram_bus_driver (
      .slot             (slot),
      .mcr_addr         (mcr_addr),
      .mcr_data_in      (mcr_data_in),
      .mcr_write        (mcr_write),
      .vram_vga_addr    (vram_vga_addr),
      .vram_vga_req     (vram_vga_req),
      .vram_cpu_addr    (vram_cpu_addr),
      .vram_cpu_data_in (vram_cpu_data_in),
      .vram_cpu_req     (vram_cpu_req),
      .vram_cpu_write   (vram_cpu_write),
      .vram_cpu_busy    (vram_cpu_busy),
      .main_addr        (main_addr),
      .main_data_in     (main_data_in),
      .main_req         (main_req),
      .main_write       (main_write),
      .main_busy        (main_busy),
      .s6_access        (s6_access),
      .sram_a           (sram_a),
      .sram_oe_n        (sram_oe_n),
      .sram_we_n        (sram_we_n),
      .sram_dq_out      (sram_dq_out),
      .sram_dq_oe       (sram_dq_oe)
   );

   // ----------------------------------------
   // client side
   // ----------------------------------------
   port_capture #(
      .main_limit_bits (main_limit_bits)
   ) u_port_capture (
      .clk               (clk),
      .reset             (reset),
      .slot              (slot),
      .s6_access         (s6_access),
      .sram_dq_in        (sram_dq_in),
      .mcr_write         (mcr_write),
      .vram_vga_req      (vram_vga_req),
      .vram_cpu_req      (vram_cpu_req),
      .vram_cpu_write    (vram_cpu_write),
      .main_addr         (main_addr),
      .main_req          (main_req),
      .main_write        (main_write),
      .mcr_data_out      (mcr_data_out),
      .mcr_ready         (mcr_ready),
      .mcr_done          (mcr_done),
      .vram_vga_data_out (vram_vga_data_out),
      .vram_vga_ready    (vram_vga_ready),
      .vram_cpu_data_out (vram_cpu_data_out),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_cpu_done     (vram_cpu_done),
      .vram_cpu_busy     (vram_cpu_busy),
      .main_data_out     (main_data_out),
      .main_ready        (main_ready),
      .main_done         (main_done),
      .main_busy         (main_busy)
   );

endmodule

`default_nettype wire

/* testbench/sram_model.sv */
// asynchronous sram model: 2^18 words of 32 bits, clocked write, combinational read
`default_nettype none
`timescale 1ns/1ps

module sram_model
   import mem_map_pkg::*;
(
   input  wire                    clk,
   input  wire [sram_addr_w-1:0]  a,
   input  wire                    oe_n,
   input  wire                    we_n,
   input  wire [sram_data_w-1:0]  dq_in,
   output logic [sram_data_w-1:0] dq_out
);

   logic [sram_data_w-1:0] mem [0:(1<<sram_addr_w)-1];

   // ----------------------------------------
   // power-up contents
   // ----------------------------------------
   // pattern built from the full address
   initial
   begin
      for (int i = 0; i < (1 << sram_addr_w); i++)
      begin
         mem[i] = {i[17:0], i[13:0]} ^ 32'h5a5a_c3c3;
      end
   end

   // ----------------------------------------
   // write, sampled at the clock edge
   // ----------------------------------------
   always @(posedge clk)
   begin
      if (!we_n)
      begin
         mem[a] <= dq_in;
      end
   end

   // read path, no latency
   assign dq_out = oe_n ? '0 : mem[a];

endmodule

`default_nettype wire

/* testbench/tb_ram_controller.sv */
// testbench for the ram controller: four clients against a shadow memory
`default_nettype none
`timescale 1ns/1ps

module tb_ram_controller
   import mem_map_pkg::*;
();

   localparam int cl_mcr = 0;
   localparam int cl_vram = 1;
   localparam int cl_main = 2;
   localparam int timeout_clks = 100;

   logic clk;
   logic reset;
   logic prefetch;
   logic [mcr_addr_w-1:0] mcr_addr;
   logic [mcr_data_w-1:0] mcr_data_in;
   logic mcr_write;
   logic [mcr_data_w-1:0] mcr_data_out;
   logic mcr_ready;
   logic mcr_done;
   logic [vram_addr_w-1:0] vram_vga_addr;
   logic vram_vga_req;
   logic [sram_data_w-1:0] vram_vga_data_out;
   logic vram_vga_ready;
   logic [vram_addr_w-1:0] vram_cpu_addr;
   logic [sram_data_w-1:0] vram_cpu_data_in;
   logic vram_cpu_req;
   logic vram_cpu_write;
   logic [sram_data_w-1:0] vram_cpu_data_out;
   logic vram_cpu_ready;
   logic vram_cpu_done;
   logic [main_addr_w-1:0] main_addr;
   logic [sram_data_w-1:0] main_data_in;
   logic main_req;
   logic main_write;
   logic [sram_data_w-1:0] main_data_out;
   logic main_ready;
   logic main_done;
   logic [sram_addr_w-1:0] sram_a;
   logic sram_oe_n;
   logic sram_we_n;
   logic [sram_data_w-1:0] sram_dq_out;
   logic sram_dq_oe;
   logic [sram_data_w-1:0] sram_dq_in;

   // compare queues filled by the client tasks
   logic [48:0] got_q [$];
   logic [48:0] exp_q [$];
   string name_q [$];
   int mismatches;
   int timeouts;
   logic [31:0] shadow [logic [sram_addr_w-1:0]];
   logic [31:0] lcg_state;

   ram_controller #(.main_limit_bits(5)) u_ram_controller (.*);

   sram_model u_sram (
      .clk    (clk),
      .a      (sram_a),
      .oe_n   (sram_oe_n),
      .we_n   (sram_we_n),
      .dq_in  (sram_dq_out),
      .dq_out (sram_dq_in)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ----------------------------------------
   // reference model
   // ----------------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [sram_addr_w-1:0] model_addr(int client,
         logic [main_addr_w-1:0] addr, logic half);
      if (client == cl_mcr)
         return {mcr_prefix, addr[mcr_addr_w-1:0], half};
      if (client == cl_vram)
         return {vram_prefix, addr[vram_addr_w-1:0]};
      return {1'b0, addr[main_sram_w-1:0]};
   endfunction

   function automatic logic in_range(logic [main_addr_w-1:0] addr);
      return addr[main_addr_w-1:main_sram_w] == '0;
   endfunction

   // unwritten words still hold the power-up pattern
   function automatic logic [31:0] stored(logic [sram_addr_w-1:0] a);
      if (shadow.exists(a))
         return shadow[a];
      return {a, a[13:0]} ^ 32'h5a5a_c3c3;
   endfunction

   function automatic logic [48:0] ref_expect(int client, logic [main_addr_w-1:0] addr);
      logic [31:0] hi;
      logic [31:0] lo;
      hi = stored(model_addr(client, addr, 1'b0));
      lo = stored(model_addr(client, addr, 1'b1));
      if (client == cl_mcr)
         return {hi[16:0], lo};
      if (client == cl_main && !in_range(addr))
         return {17'b0, 32'hffff_ffff};
      return {17'b0, hi};
   endfunction

   function automatic void record_write(int client, logic [main_addr_w-1:0] addr,
         logic [48:0] data);
      if (client == cl_mcr)
      begin
         shadow[model_addr(cl_mcr, addr, 1'b0)] = {15'b0, data[48:32]};
         shadow[model_addr(cl_mcr, addr, 1'b1)] = data[31:0];
      end
      // dropped writes leave the sram alone
      else if (client != cl_main || in_range(addr))
         shadow[model_addr(client, addr, 1'b0)] = data[31:0];
   endfunction

   // ----------------------------------------
   // compare
   // ----------------------------------------
   task automatic check_value(string name, logic [48:0] got, logic [48:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
         mismatches++;
      end
   endtask

   task automatic push_result(string name, logic [48:0] got, logic [48:0] exp);
      name_q.push_back(name);
      got_q.push_back(got);
      exp_q.push_back(exp);
   endtask

   always @(posedge clk)
   begin
      while (got_q.size() > 0)
         check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
   end

   // write data is on the bus exactly while the write strobe is low
   always @(negedge clk)
   begin
      if (!reset)
         check_value("sram_dq_oe", sram_dq_oe, !sram_we_n);
   end

   // ----------------------------------------
   // client drivers
   // ----------------------------------------
   // wait for the next mcr_ready pulse as seen 1 ns after the edge
   task automatic mcr_sync();
      int n;
      n = 0;
      @(posedge clk);
      #1;
      while (!mcr_ready && n < timeout_clks)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!mcr_ready)
      begin
         $display("timeout waiting for mcr_ready");
         timeouts++;
      end
   endtask

   task automatic mcr_transfer(logic wr, logic [mcr_addr_w-1:0] addr, logic [48:0] data);
      // inputs change in s3 so the next s1/s2 pair sees them whole
      mcr_sync();
      mcr_addr = addr;
      mcr_data_in = data;
      mcr_write = wr;
      if (wr)
         record_write(cl_mcr, addr, data);
      mcr_sync();
      if (wr)
         push_result("mcr_done", mcr_done, 1);
      else
         push_result("mcr_data_out", mcr_data_out, ref_expect(cl_mcr, addr));
      mcr_write = 1'b0;
   endtask

   task automatic vram_cpu_access(logic wr, logic [vram_addr_w-1:0] addr, logic [31:0] data);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      vram_cpu_addr = addr;
      vram_cpu_data_in = data;
      vram_cpu_write = wr;
      vram_cpu_req = !wr;
      if (wr)
         record_write(cl_vram, addr, data);
      while (!(wr ? vram_cpu_done : vram_cpu_ready) && n < timeout_clks)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!(wr ? vram_cpu_done : vram_cpu_ready))
      begin
         $display("timeout waiting for vram cpu flag, addr %h", addr);
         timeouts++;
      end
      else if (!wr)
         push_result("vram_cpu_data_out", vram_cpu_data_out, ref_expect(cl_vram, addr));
      vram_cpu_req = 1'b0;
      vram_cpu_write = 1'b0;
      // flag is gone one clock after the request
      @(posedge clk);
      #1;
      push_result("vram_cpu flag", vram_cpu_ready | vram_cpu_done, 0);
   endtask

   task automatic main_access(logic wr, logic [main_addr_w-1:0] addr, logic [31:0] data);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      main_addr = addr;
      main_data_in = data;
      main_write = wr;
      main_req = !wr;
      if (wr)
         record_write(cl_main, addr, data);
      while (!(wr ? main_done : main_ready) && n < timeout_clks)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!(wr ? main_done : main_ready))
      begin
         $display("timeout waiting for main memory flag, addr %h", addr);
         timeouts++;
      end
      else if (!wr)
         push_result("main_data_out", main_data_out, ref_expect(cl_main, addr));
      main_req = 1'b0;
      main_write = 1'b0;
      @(posedge clk);
      #1;
      push_result("main flag", main_ready | main_done, 0);
   endtask

   task automatic vga_read(logic [vram_addr_w-1:0] addr);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      vram_vga_addr = addr;
      vram_vga_req = 1'b1;
      while (!vram_vga_ready && n < timeout_clks)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!vram_vga_ready)
      begin
         $display("timeout waiting for vram_vga_ready, addr %h", addr);
         timeouts++;
      end
      else
         push_result("vram_vga_data_out", vram_vga_data_out, ref_expect(cl_vram, addr));
      vram_vga_req = 1'b0;
      @(posedge clk);
      #1;
      push_result("vram_vga_ready", vram_vga_ready, 0);
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial
   begin
      logic [mcr_addr_w-1:0] ma [6];
      logic [48:0] mw [6];
      logic [vram_addr_w-1:0] va [6];
      logic [main_addr_w-1:0] xa [6];
      logic [31:0] r1;
      logic [31:0] r2;
      int pulses;
      int n;
      lcg_state = 32'd23328;
      mismatches = 0;
      timeouts = 0;
      reset = 1'b1;
      prefetch = 1'b0;
      mcr_addr = '0;
      mcr_data_in = '0;
      mcr_write = 1'b0;
      vram_vga_addr = '0;
      vram_vga_req = 1'b0;
      vram_cpu_addr = '0;
      vram_cpu_data_in = '0;
      vram_cpu_req = 1'b0;
      vram_cpu_write = 1'b0;
      main_addr = '0;
      main_data_in = '0;
      main_req = 1'b0;
      main_write = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      prefetch = 1'b1;

      // microcode round trip
      for (int i = 0; i < 6; i++)
      begin
         r1 = lcg_next();
         r2 = lcg_next();
         ma[i] = r1[29:16];
         mw[i] = {r1[16:0], r2};
         mcr_transfer(1'b1, ma[i], mw[i]);
      end
      for (int i = 0; i < 6; i++)
         mcr_transfer(1'b0, ma[i], '0);

      // cpu video and main memory round trip
      for (int i = 0; i < 6; i++)
      begin
         r1 = lcg_next();
         va[i] = r1[vram_addr_w-1:0];
         xa[i] = {5'b0, r1[31:15]};
         vram_cpu_access(1'b1, va[i], lcg_next());
         main_access(1'b1, xa[i], lcg_next());
      end
      for (int i = 0; i < 6; i++)
      begin
         vram_cpu_access(1'b0, va[i], '0);
         main_access(1'b0, xa[i], '0);
      end

      // same low address in all three partitions
      mcr_transfer(1'b1, 14'd7, 49'h1_0000_1111_1111);
      vram_cpu_access(1'b1, 15'd7, 32'h2222_2222);
      main_access(1'b1, 22'd7, 32'h3333_3333);
      mcr_transfer(1'b0, 14'd7, '0);
      vram_cpu_access(1'b0, 15'd7, '0);
      main_access(1'b0, 22'd7, '0);

      // display sees cpu video writes
      vram_cpu_access(1'b1, 15'h1abc, 32'hcafe_0123);
      vga_read(15'h1abc);
      vga_read(va[2]);

      // out of range main memory
      main_access(1'b1, 22'h00_0123, 32'h0bad_f00d);
      main_access(1'b1, 22'h00_0123 | (22'd1 << main_sram_w), 32'hdead_beef);
      main_access(1'b0, 22'h00_0123, '0);
      main_access(1'b0, 22'h00_0123 | (22'd1 << main_sram_w), '0);

      // both s6 clients at once
      fork
         vram_cpu_access(1'b1, 15'h0042, 32'h4444_0042);
         main_access(1'b1, 22'h00_0042, 32'h5555_0042);
      join
      fork
         vram_cpu_access(1'b0, 15'h0042, '0);
         main_access(1'b0, 22'h00_0042, '0);
      join

      // prefetch low parks the cycle in s1
      prefetch = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      pulses = 0;
      for (int i = 0; i < 20; i++)
      begin
         @(posedge clk);
         #1;
         if (mcr_ready)
            pulses++;
      end
      push_result("mcr_ready pulses", pulses, 0);

      n = 0;
      while (got_q.size() > 0 && n < timeout_clks)
      begin
         @(posedge clk);
         n++;
      end
      if (got_q.size() > 0)
      begin
         $display("compare queue still holds %0d results", got_q.size());
         timeouts++;
      end
      $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
hw/mem_map_pkg.sv
hw/slot_pkg.sv
hw/slot_sequencer.sv
hw/sram_bus_driver.sv
hw/port_capture.sv
hw/ram_controller.sv
testbench/sram_model.sv
testbench/tb_ram_controller.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ram controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_ram_controller -f sources.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
   exit 0
else
   exit 1
fi
